/* hdl/isa_pkg.sv */
package isa_pkg;

    localparam int OP_W      = 6;
    localparam int REG_IDX_W = 5;
    localparam int IMM_W     = 16;

    typedef enum logic [OP_W-1:0] {
        OP_ADD  = 6'h01,
        OP_SUB  = 6'h02,
        OP_AND  = 6'h03,
        OP_OR   = 6'h04,
        OP_XOR  = 6'h05,
        OP_ADDI = 6'h0a,
        OP_MUL  = 6'h10
    } opcode_e;

    // three-register form
    typedef struct packed {
        opcode_e              op;
        logic [REG_IDX_W-1:0] rd;
        logic [REG_IDX_W-1:0] rj;
        logic [REG_IDX_W-1:0] rk;
        logic [10:0]          unused;
    } r_fmt_t;

    // immediate form, only OP_ADDI uses it
    typedef struct packed {
        opcode_e              op;
        logic [REG_IDX_W-1:0] rd;
        logic [REG_IDX_W-1:0] rj;
        logic signed [IMM_W-1:0] imm;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

endpackage

/* hdl/pipe_pkg.sv */
package pipe_pkg;

    localparam int NUM_LANES  = 2;
    // j and k per lane
    localparam int NUM_OPNDS  = 2 * NUM_LANES;
    // ex1_ex2, ex2_ex3 and ex3_wb
    localparam int NUM_STAGES = 3;
    localparam int NUM_REGS   = 32;

    typedef logic [isa_pkg::REG_IDX_W-1:0] reg_idx_t;
    typedef logic [31:0]                   word_t;

    typedef struct packed {
        logic            valid;
        isa_pkg::instr_u instr;
    } issue_t;

    typedef struct packed {
        logic     valid;
        logic     wen;
        reg_idx_t rd;
        logic     ready;
        logic     is_mul;
        word_t    data;
        word_t    mul_b;
    } result_t;

    // lane 1 is the younger of the pair
    typedef result_t [NUM_LANES-1:0] stage_bus_t;

    typedef struct packed {
        logic     used;
        reg_idx_t idx;
        word_t    rf_data;
    } operand_req_t;

endpackage

/* hdl/reg_file.sv */
`timescale 1ns/100ps

module reg_file (
    input  logic                                          clk,
    input  logic                                          reset_i,
    input  pipe_pkg::reg_idx_t [pipe_pkg::NUM_OPNDS-1:0]  rd_idx_i,
    output pipe_pkg::word_t    [pipe_pkg::NUM_OPNDS-1:0]  rd_data_o,
    input  pipe_pkg::stage_bus_t                          wb_i
);
    import pipe_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            // ascending order so lane 1 lands last on a shared rd
            for (int l = 0; l < NUM_LANES; l++) begin
                if (wb_i[l].valid && wb_i[l].wen) begin
                    regs[wb_i[l].rd] <= wb_i[l].data;
                end
            end
        end
    end

    always_comb begin
        for (int p = 0; p < NUM_OPNDS; p++) begin
            if (rd_idx_i[p] == '0) begin
                rd_data_o[p] = '0;
            end else begin
                rd_data_o[p] = regs[rd_idx_i[p]];
            end
        end
    end

    // r0 is never a write target, whatever the decode upstream saw
    for (genvar l = 0; l < NUM_LANES; l++) begin : g_wb_chk
        assert property (@(posedge clk) disable iff (reset_i)
            (wb_i[l].valid && (wb_i[l].rd == '0)) |-> !wb_i[l].wen)
            else $error("reg_file: lane %0d writes r0", l);
    end

endmodule

/* hdl/ex1_forward.sv */
`timescale 1ns/100ps

module ex1_forward (
    input  pipe_pkg::operand_req_t [pipe_pkg::NUM_OPNDS-1:0] req_i,
    input  pipe_pkg::stage_bus_t                             ex1_ex2_i,
    input  pipe_pkg::stage_bus_t                             ex2_ex3_i,
    input  pipe_pkg::stage_bus_t                             ex3_wb_i,
    output pipe_pkg::word_t        [pipe_pkg::NUM_OPNDS-1:0] opnd_o,
    output logic                                             stall_o
);
    import pipe_pkg::*;

    // youngest boundary first
    stage_bus_t [NUM_STAGES-1:0] stages;
    logic       [NUM_OPNDS-1:0]  opnd_stall;
    logic       [NUM_OPNDS-1:0]  mul_wait;

    assign stages[0] = ex1_ex2_i;
    assign stages[1] = ex2_ex3_i;
    assign stages[2] = ex3_wb_i;

    function automatic logic src_hit(result_t src, operand_req_t req);
        return src.valid && src.wen && (src.rd == req.idx);
    endfunction

    function automatic logic req_live(operand_req_t req);
        return req.used && (req.idx != '0);
    endfunction

    always_comb begin
        logic found;
        for (int o = 0; o < NUM_OPNDS; o++) begin
            opnd_o[o]     = req_i[o].rf_data;
            opnd_stall[o] = 1'b0;
            found         = 1'b0;
            if (req_live(req_i[o])) begin
                for (int b = 0; b < NUM_STAGES; b++) begin
                    // lane 1 before lane 0 within a boundary
                    for (int l = NUM_LANES - 1; l >= 0; l--) begin
                        if (!found && src_hit(stages[b][l], req_i[o])) begin
                            found = 1'b1;
                            if (stages[b][l].ready) begin
                                opnd_o[o] = stages[b][l].data;
                            end else begin
                                opnd_stall[o] = 1'b1;
                            end
                        end
                    end
                end
            end
        end
    end

    // any operand waiting holds the whole pair
    assign stall_o = |opnd_stall;

    // only a multiply still in ex1_ex2 is unfinished, later boundaries are final
    always_comb begin
        mul_wait = '0;
        for (int o = 0; o < NUM_OPNDS; o++) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                if (req_live(req_i[o]) && src_hit(ex1_ex2_i[l], req_i[o]) &&
                    ex1_ex2_i[l].is_mul) begin
                    mul_wait[o] = 1'b1;
                end
            end
        end
    end

    always_comb begin
        assert (!stall_o || (|mul_wait))
            else $error("ex1_forward: stall with no multiply waiting in ex1_ex2");
    end

endmodule

/* hdl/lane_alu.sv */
`timescale 1ns/100ps

module lane_alu (
    input  pipe_pkg::issue_t       instr_i,
    input  pipe_pkg::word_t        rf_j_i,
    input  pipe_pkg::word_t        rf_k_i,
    input  pipe_pkg::word_t        opnd_j_i,
    input  pipe_pkg::word_t        opnd_k_i,
    output pipe_pkg::operand_req_t req_j_o,
    output pipe_pkg::operand_req_t req_k_o,
    output pipe_pkg::result_t      result_o
);
    import isa_pkg::*;
    import pipe_pkg::*;

    opcode_e op;
    logic    is_imm;
    logic    is_mul;
    word_t   imm_ext;
    word_t   alu_out;

    assign op      = instr_i.instr.r.op;
    assign is_imm  = (op == OP_ADDI);
    assign is_mul  = (op == OP_MUL);
    // same word seen through the i format
    assign imm_ext = {{($bits(word_t) - IMM_W){instr_i.instr.i.imm[IMM_W-1]}},
                      instr_i.instr.i.imm};

    assign req_j_o = '{used: instr_i.valid, idx: instr_i.instr.r.rj, rf_data: rf_j_i};
    // rk bits hold the immediate for addi
    assign req_k_o = '{used: instr_i.valid && !is_imm, idx: instr_i.instr.r.rk,
                       rf_data: rf_k_i};

    always_comb begin
        case (op)
            OP_ADD:  alu_out = opnd_j_i + opnd_k_i;
            OP_SUB:  alu_out = opnd_j_i - opnd_k_i;
            OP_AND:  alu_out = opnd_j_i & opnd_k_i;
            OP_OR:   alu_out = opnd_j_i | opnd_k_i;
            OP_XOR:  alu_out = opnd_j_i ^ opnd_k_i;
            OP_ADDI: alu_out = opnd_j_i + imm_ext;
            default: alu_out = '0;
        endcase
    end

    always_comb begin
        result_o.valid  = instr_i.valid;
        result_o.wen    = instr_i.valid && (instr_i.instr.r.rd != '0);
        result_o.rd     = instr_i.instr.r.rd;
        result_o.ready  = !is_mul;
        result_o.is_mul = is_mul;
        // multiply carries both operands on to ex2
        result_o.data   = is_mul ? opnd_j_i : alu_out;
        result_o.mul_b  = opnd_k_i;
    end

endmodule

/* hdl/mul_unit.sv */
`timescale 1ns/100ps

module mul_unit (
    input  pipe_pkg::stage_bus_t bus_i,
    output pipe_pkg::stage_bus_t bus_o
);
    import pipe_pkg::*;

    always_comb begin
        bus_o = bus_i;
        for (int l = 0; l < NUM_LANES; l++) begin
            if (bus_i[l].is_mul) begin
                // low 32 bits of the product
                bus_o[l].data  = bus_i[l].data * bus_i[l].mul_b;
                bus_o[l].ready = 1'b1;
            end
        end
    end

    // only multiply can leave ex1 unfinished, so ex2 closes every lane
    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            assert (!bus_o[l].valid || bus_o[l].ready)
                else $error("mul_unit: lane %0d leaves ex2 unready", l);
        end
    end

endmodule

/* hdl/exec_pipe.sv */
`timescale 1ns/100ps

module exec_pipe (
    input  logic                                       clk,
    input  logic                                       reset_i,
    input  pipe_pkg::issue_t [pipe_pkg::NUM_LANES-1:0] issue_i,
    output logic                                       stall_o,
    output pipe_pkg::stage_bus_t                       commit_o
);
    import pipe_pkg::*;

    issue_t       [NUM_LANES-1:0] ex1_q;
    stage_bus_t                   ex1_res;
    stage_bus_t                   ex1_next;
    stage_bus_t                   ex2_res;
    stage_bus_t                   ex1_ex2_q;
    stage_bus_t                   ex2_ex3_q;
    stage_bus_t                   ex3_wb_q;
    reg_idx_t     [NUM_OPNDS-1:0] rf_idx;
    word_t        [NUM_OPNDS-1:0] rf_data;
    operand_req_t [NUM_OPNDS-1:0] reqs;
    word_t        [NUM_OPNDS-1:0] opnds;

    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        // ports 2l and 2l+1 carry rj and rk of lane l
        assign rf_idx[2*l]   = ex1_q[l].instr.r.rj;
        assign rf_idx[2*l+1] = ex1_q[l].instr.r.rk;

        lane_alu u_alu (
            .instr_i  (ex1_q[l]),
            .rf_j_i   (rf_data[2*l]),
            .rf_k_i   (rf_data[2*l+1]),
            .opnd_j_i (opnds[2*l]),
            .opnd_k_i (opnds[2*l+1]),
            .req_j_o  (reqs[2*l]),
            .req_k_o  (reqs[2*l+1]),
            .result_o (ex1_res[l])
        );
    end

    reg_file u_rf (
        .clk       (clk),
        .reset_i   (reset_i),
        .rd_idx_i  (rf_idx),
        .rd_data_o (rf_data),
        .wb_i      (ex3_wb_q)
    );

    ex1_forward u_fwd (
        .req_i     (reqs),
        .ex1_ex2_i (ex1_ex2_q),
        .ex2_ex3_i (ex2_ex3_q),
        .ex3_wb_i  (ex3_wb_q),
        .opnd_o    (opnds),
        .stall_o   (stall_o)
    );

    mul_unit u_mul (
        .bus_i (ex1_ex2_q),
        .bus_o (ex2_res)
    );

    // held pair sends a bubble down
    always_comb begin
        ex1_next = ex1_res;
        if (stall_o) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                ex1_next[l].valid = 1'b0;
                ex1_next[l].wen   = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                ex1_q[l].valid     <= 1'b0;
                ex1_ex2_q[l].valid <= 1'b0;
                ex1_ex2_q[l].wen   <= 1'b0;
                ex2_ex3_q[l].valid <= 1'b0;
                ex2_ex3_q[l].wen   <= 1'b0;
                ex3_wb_q[l].valid  <= 1'b0;
                ex3_wb_q[l].wen    <= 1'b0;
            end
        end else begin
            if (!stall_o) begin
                ex1_q <= issue_i;
            end
            ex1_ex2_q <= ex1_next;
            ex2_ex3_q <= ex2_res;
            ex3_wb_q  <= ex2_ex3_q;
        end
    end

    assign commit_o = ex3_wb_q;

    for (genvar l = 0; l < NUM_LANES; l++) begin : g_commit_chk
        assert property (@(posedge clk) disable iff (reset_i)
            commit_o[l].valid |-> commit_o[l].ready)
            else $error("exec_pipe: lane %0d commits an unfinished result", l);
    end

    // the bubble behind a multiply always clears the hazard
    assert property (@(posedge clk) disable iff (reset_i) stall_o |=> !stall_o)
        else $error("exec_pipe: stall held for more than one cycle");

endmodule

/* dv/tb_exec_pipe.sv */
`timescale 1ns/100ps

module tb_exec_pipe;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int STALL_LIMIT = 4;
    localparam int DRAIN_LIMIT = 40;
    localparam int NUM_RANDOM  = 400;

    typedef issue_t [NUM_LANES-1:0] pair_t;

    logic       clk;
    logic       reset_i;
    pair_t      issue_i;
    logic       stall_o;
    stage_bus_t commit_o;

    logic [31:0] lfsr_state;
    word_t       model_regs [NUM_REGS];
    result_t     exp_q [$];
    pair_t       last_pair;
    logic        exp_stall;
    int          issued;
    int          commits;

    exec_pipe DUT (
        .clk      (clk),
        .reset_i  (reset_i),
        .issue_i  (issue_i),
        .stall_o  (stall_o),
        .commit_o (commit_o)
    );

    always #50 clk = ~clk;

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("error t=%0t %s got 0x%08h expected 0x%08h",
                                     $time, name, got, exp));
        end
    endtask

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int b = 0; b < n; b++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v          = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic issue_t reg_op(input opcode_e op, input int rd, input int rj,
                                      input int rk);
        issue_t it;
        it.valid   = 1'b1;
        it.instr.r = '{op: op, rd: reg_idx_t'(rd), rj: reg_idx_t'(rj),
                       rk: reg_idx_t'(rk), unused: '0};
        return it;
    endfunction

    function automatic issue_t imm_op(input int rd, input int rj, input int imm);
        issue_t it;
        it.valid   = 1'b1;
        it.instr.i = '{op: OP_ADDI, rd: reg_idx_t'(rd), rj: reg_idx_t'(rj),
                       imm: 16'(imm)};
        return it;
    endfunction

    function automatic issue_t rand_lane();
        issue_t     it;
        opcode_e    op;
        logic [2:0] sel;
        int         rd;
        int         rj;
        int         rk;
        sel = 3'(next_bits(3));
        case (sel)
            3'd0:    op = OP_ADD;
            3'd1:    op = OP_SUB;
            3'd2:    op = OP_AND;
            3'd3:    op = OP_OR;
            3'd4:    op = OP_XOR;
            3'd5:    op = OP_ADDI;
            default: op = OP_MUL;
        endcase
        rd = int'(next_bits(3));
        rj = int'(next_bits(3));
        rk = int'(next_bits(3));
        if (op == OP_ADDI) begin
            it = imm_op(rd, rj, int'(next_bits(16)));
        end else begin
            it = reg_op(op, rd, rj, rk);
        end
        it.valid = (3'(next_bits(3)) != 3'd0);
        return it;
    endfunction

    function automatic pair_t rand_pair();
        pair_t pair;
        pair[0] = rand_lane();
        pair[1] = rand_lane();
        // lane 1 must not read what lane 0 writes
        if (pair[0].valid) begin
            if (pair[1].instr.r.rj == pair[0].instr.r.rd) begin
                pair[1].instr.r.rj = '0;
            end
            if (pair[1].instr.r.rk == pair[0].instr.r.rd) begin
                pair[1].instr.r.rk = '0;
            end
        end
        return pair;
    endfunction

    // reference model, lanes executed in program order
    function automatic stage_bus_t ref_pair(input pair_t pair);
        stage_bus_t res;
        word_t      a;
        word_t      b;
        word_t      imm;
        res = '0;
        for (int l = 0; l < NUM_LANES; l++) begin
            a   = model_regs[pair[l].instr.r.rj];
            b   = model_regs[pair[l].instr.r.rk];
            imm = {{16{pair[l].instr.i.imm[15]}}, pair[l].instr.i.imm};
            res[l].valid = pair[l].valid;
            res[l].wen   = pair[l].valid && (pair[l].instr.r.rd != '0);
            res[l].rd    = pair[l].instr.r.rd;
            res[l].ready = 1'b1;
            res[l].is_mul = (pair[l].instr.r.op == OP_MUL);
            res[l].mul_b  = b;
            case (pair[l].instr.r.op)
                OP_ADD:  res[l].data = a + b;
                OP_SUB:  res[l].data = a - b;
                OP_AND:  res[l].data = a & b;
                OP_OR:   res[l].data = a | b;
                OP_XOR:  res[l].data = a ^ b;
                OP_ADDI: res[l].data = a + imm;
                OP_MUL:  res[l].data = a * b;
                default: res[l].data = '0;
            endcase
            if (res[l].wen) begin
                model_regs[res[l].rd] = res[l].data;
            end
        end
        return res;
    endfunction

    // younger pair reads a multiply of the pair directly ahead of it
    function automatic logic mul_hazard(input pair_t older, input pair_t younger);
        reg_idx_t src;
        logic     live;
        logic     found;
        logic     hit;
        hit = 1'b0;
        for (int o = 0; o < 2 * NUM_LANES; o++) begin
            src   = (o % 2 == 0) ? younger[o / 2].instr.r.rj : younger[o / 2].instr.r.rk;
            live  = younger[o / 2].valid && (src != '0) &&
                    ((o % 2 == 0) || (younger[o / 2].instr.r.op != OP_ADDI));
            found = 1'b0;
            for (int l = NUM_LANES - 1; l >= 0; l--) begin
                if (live && !found && older[l].valid && (older[l].instr.r.rd == src)) begin
                    found = 1'b1;
                    hit   = hit | (older[l].instr.r.op == OP_MUL);
                end
            end
        end
        return hit;
    endfunction

    task automatic issue_pair(input issue_t l0, input issue_t l1);
        pair_t      pair;
        stage_bus_t exp;
        int         waited;
        pair[0] = l0;
        pair[1] = l1;
        issue_i = pair;
        waited  = 0;
        while (stall_o) begin
            waited++;
            if (waited > STALL_LIMIT) begin
                report_failure("stall_o stuck high, the pipeline never took the pair");
            end else begin
                @(negedge clk);
            end
        end
        check_value("stall_o cycles", 32'(waited), 32'(exp_stall));
        exp_stall = mul_hazard(last_pair, pair);
        last_pair = pair;
        exp       = ref_pair(pair);
        for (int l = 0; l < NUM_LANES; l++) begin
            if (exp[l].valid) begin
                exp_q.push_back(exp[l]);
                issued++;
            end
        end
        @(negedge clk);
    endtask

    always @(negedge clk) begin
        result_t exp;
        if (!reset_i) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                if (commit_o[l].valid) begin
                    commits++;
                end
                if (commit_o[l].valid && exp_q.size() != 0) begin
                    exp = exp_q.pop_front();
                    check_value($sformatf("commit_o[%0d].rd", l), 32'(commit_o[l].rd),
                                32'(exp.rd));
                    check_value($sformatf("commit_o[%0d].wen", l), 32'(commit_o[l].wen),
                                32'(exp.wen));
                    check_value($sformatf("commit_o[%0d].data", l), commit_o[l].data,
                                exp.data);
                    check_value($sformatf("commit_o[%0d].ready", l), 32'(commit_o[l].ready),
                                32'(exp.ready));
                    check_value($sformatf("commit_o[%0d].is_mul", l),
                                32'(commit_o[l].is_mul), 32'(exp.is_mul));
                    // second operand only defined for a multiply
                    if (exp.is_mul) begin
                        check_value($sformatf("commit_o[%0d].mul_b", l), commit_o[l].mul_b,
                                    exp.mul_b);
                    end
                end
            end
        end
    end

    initial begin
        pair_t  pair;
        issue_t nop;
        int     waited;
        clk        = 1'b0;
        reset_i    = 1'b1;
        issue_i    = '0;
        nop        = '0;
        last_pair  = '0;
        exp_stall  = 1'b0;
        issued     = 0;
        commits    = 0;
        lfsr_state = 32'h507f_69e2;
        for (int r = 0; r < NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        repeat (3) @(negedge clk);
        reset_i = 1'b0;
        check_value("stall_o", 32'(stall_o), 32'd0);
        check_value("commit_o[0].valid", 32'(commit_o[0].valid), 32'd0);
        check_value("commit_o[1].valid", 32'(commit_o[1].valid), 32'd0);

        issue_pair(reg_op(OP_ADD, 1, 2, 3), reg_op(OP_SUB, 4, 5, 6));
        // alu chain at distances 1, 2 and 3
        issue_pair(imm_op(1, 0, 5), imm_op(2, 0, -3));
        issue_pair(reg_op(OP_ADD, 3, 1, 2), reg_op(OP_SUB, 4, 1, 2));
        issue_pair(reg_op(OP_XOR, 5, 3, 1), reg_op(OP_OR, 6, 4, 2));
        issue_pair(reg_op(OP_AND, 7, 5, 2), reg_op(OP_ADD, 1, 6, 1));
        // multiply then a direct reader, then a reader two pairs back
        issue_pair(reg_op(OP_MUL, 3, 1, 2), imm_op(4, 0, 7));
        issue_pair(reg_op(OP_ADD, 5, 3, 4), nop);
        issue_pair(reg_op(OP_MUL, 6, 5, 5), nop);
        issue_pair(imm_op(2, 1, 1), nop);
        issue_pair(reg_op(OP_SUB, 7, 6, 2), nop);
        // same rd in both lanes
        issue_pair(imm_op(2, 0, 11), imm_op(2, 0, 22));
        issue_pair(reg_op(OP_ADD, 3, 2, 0), nop);
        // r0 as a target, read back right behind it
        issue_pair(imm_op(0, 1, 99), reg_op(OP_MUL, 0, 1, 1));
        issue_pair(reg_op(OP_ADD, 4, 0, 0), reg_op(OP_OR, 5, 0, 1));

        for (int n = 0; n < NUM_RANDOM; n++) begin
            pair = rand_pair();
            issue_pair(pair[0], pair[1]);
        end
        repeat (4) issue_pair(nop, nop);

        waited = 0;
        while (exp_q.size() != 0) begin
            waited++;
            if (waited > DRAIN_LIMIT) begin
                report_failure("pipeline did not drain, expected commits never arrived");
            end else begin
                @(negedge clk);
            end
        end
        if (commits == issued) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            report_failure($sformatf("error t=%0t commit count got %0d expected %0d",
                                     $time, commits, issued));
        end
    end

endmodule

/* build.f */
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/reg_file.sv
hdl/ex1_forward.sv
hdl/lane_alu.sv
hdl/mul_unit.sv
hdl/exec_pipe.sv
dv/tb_exec_pipe.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_exec_pipe -f build.f -o sim_exec_pipe
./obj_dir/sim_exec_pipe
